/* include/rp_consts.svh */
`ifndef RP_CONSTS_SVH
`define RP_CONSTS_SVH

////////////////////
// machine widths
////////////////////

// data, address and instruction width
`define RP_XW 32

// general register address width, 32 entries
`define RP_AW 5

////////////////////
// fixed values
////////////////////

// program counter after reset
`define RP_PC0 32'h0000_0000

// addi x0, x0, 0
`define RP_NOP 32'h0000_0013

`endif

/* run.sh */
#!/bin/sh
# build and run the rp_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module rp_core_tb -Mdir obj_dir -o rp_sim
if [ $? -ne 0 ]; then
  echo "build error"
  exit 1
fi

./obj_dir/rp_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Verification passed" sim.log; then
  exit 0
fi
exit 1

/* source/rp_alu.sv */
`timescale 1ns/10ps
`include "rp_consts.svh"

module rp_alu (
  input  rp_pkg::ao_t       ao,
  input  logic [`RP_XW-1:0] rs1,
  input  logic [`RP_XW-1:0] rs2,
  output logic [`RP_XW-1:0] rd,
  output logic [`RP_XW-1:0] sum
);

  import rp_pkg::*;

  logic [4:0] shamt;
  logic       lt;
  logic       ltu;

  ////////////////////
  // shared terms
  ////////////////////

  // plain adder, also feeds branch targets and data addresses
  assign sum = rs1 + rs2;

  // shift amount from the low five bits only
  assign shamt = rs2[4:0];

  // comparisons for slt/sltu
  assign lt  = $signed(rs1) < $signed(rs2);
  assign ltu = rs1 < rs2;

  ////////////////////
  // result select
  ////////////////////

  always_comb begin
    case (ao)
      AO_ADD:  rd = sum;
      AO_SUB:  rd = rs1 - rs2;
      AO_SLL:  rd = rs1 << shamt;
      AO_SLT:  rd = {{(`RP_XW-1){1'b0}}, lt};
      AO_SLTU: rd = {{(`RP_XW-1){1'b0}}, ltu};
      AO_XOR:  rd = rs1 ^ rs2;
      AO_SRL:  rd = rs1 >> shamt;
      // arithmetic shift keeps the sign
      AO_SRA:  rd = $unsigned($signed(rs1) >>> shamt);
      AO_OR:   rd = rs1 | rs2;
      AO_AND:  rd = rs1 & rs2;
      default: rd = sum;
    endcase
  end

endmodule

/* source/rp_br.sv */
`timescale 1ns/10ps
`include "rp_consts.svh"

module rp_br (
  input  rp_pkg::br_t       br,
  input  logic [`RP_XW-1:0] rs1,
  input  logic [`RP_XW-1:0] rs2,
  output logic              tkn
);

  import rp_pkg::*;

  logic eq;
  logic lt;
  logic ltu;

  // one compare each, shared by both polarities
  assign eq  = (rs1 == rs2);
  assign lt  = $signed(rs1) < $signed(rs2);
  assign ltu = (rs1 < rs2);

  // taken decision
  always_comb begin
    case (br)
      BR_ALW:  tkn = 1'b1;
      BR_EQ:   tkn = eq;
      BR_NE:   tkn = ~eq;
      BR_LT:   tkn = lt;
      BR_GE:   tkn = ~lt;
      BR_LTU:  tkn = ltu;
      BR_GEU:  tkn = ~ltu;
      default: tkn = 1'b0;
    endcase
  end

endmodule

/* source/rp_core.sv */
`timescale 1ns/10ps
`include "rp_consts.svh"

module rp_core #(
  parameter logic [`RP_XW-1:0] PC0 = `RP_PC0
)(
  input  logic              clk,
  input  logic              rst,
  // program bus
  output logic              bup_req,
  output logic [`RP_XW-1:0] bup_adr,
  input  logic [`RP_XW-1:0] bup_rdt,
  input  logic              bup_ack,
  // data bus
  output logic              bud_req,
  output logic              bud_wen,
  output logic [`RP_XW-1:0] bud_adr,
  output logic [`RP_XW-1:0] bud_wdt,
  input  logic [`RP_XW-1:0] bud_rdt,
  input  logic              bud_ack
);

  import rp_pkg::*;

  // fetch and pc
  logic [`RP_XW-1:0] pc;
  logic [`RP_XW-1:0] pcn;
  logic [`RP_XW-1:0] pc4;
  logic              stall;
  logic              tkn;

  // decode
  ctl_t ctl;

  // register file
  logic              gpr_we;
  logic [`RP_XW-1:0] gpr_rs1;
  logic [`RP_XW-1:0] gpr_rs2;
  logic [`RP_XW-1:0] gpr_rd;

  // alu
  logic [`RP_XW-1:0] alu_rs1;
  logic [`RP_XW-1:0] alu_rs2;
  logic [`RP_XW-1:0] alu_rd;
  logic [`RP_XW-1:0] alu_sum;

  ////////////////////
  // fetch
  ////////////////////

  // fetch request comes up one edge after reset
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bup_req <= 1'b0;
    end else begin
      bup_req <= 1'b1;
    end
  end

  // data access still waiting for its acknowledge
  assign stall = bud_req & ~bud_ack;

  assign pc4 = pc + `RP_XW'd4;

  // next pc, held while nothing can retire
  // bit 0 cleared on every target, only jalr can set it
  always_comb begin
    if (!bup_ack || stall) begin
      pcn = pc;
    end else if (tkn) begin
      pcn = {alu_sum[`RP_XW-1:1], 1'b0};
    end else begin
      pcn = pc4;
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc <= PC0;
    end else begin
      pc <= pcn;
    end
  end

  // memory sees the address one edge ahead of pc
  assign bup_adr = pcn;

  ////////////////////
  // decode and registers
  ////////////////////

  rp_dec dec (
    .inst (bup_rdt),
    .ctl  (ctl)
  );

  // write only when the instruction actually retires
  assign gpr_we = bup_ack & ~stall & (ctl.wb != WB_NONE);

  rp_gpr gpr (
    .clk   (clk),
    .rst   (rst),
    .we    (gpr_we),
    .a_rs1 (bup_rdt[19:15]),
    .a_rs2 (bup_rdt[24:20]),
    .a_rd  (bup_rdt[11:7]),
    .d_rd  (gpr_rd),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2)
  );

  ////////////////////
  // execute
  ////////////////////

  // operand select
  always_comb begin
    case (ctl.a1)
      A1_PC:   alu_rs1 = pc;
      A1_ZERO: alu_rs1 = '0;
      default: alu_rs1 = gpr_rs1;
    endcase
    alu_rs2 = (ctl.a2 == A2_IMM) ? ctl.imm : gpr_rs2;
  end

  rp_alu alu (
    .ao  (ctl.ao),
    .rs1 (alu_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  // compares raw register values next to the alu
  rp_br br (
    .br  (ctl.br),
    .rs1 (gpr_rs1),
    .rs2 (gpr_rs2),
    .tkn (tkn)
  );

  // write-back select
  always_comb begin
    case (ctl.wb)
      WB_PC4:  gpr_rd = pc4;
      WB_LD:   gpr_rd = bud_rdt;
      default: gpr_rd = alu_rd;
    endcase
  end

  ////////////////////
  // data bus
  ////////////////////

  // only while a fetched instruction is present
  assign bud_req = bup_ack & (ctl.ld | ctl.st);
  assign bud_wen = bup_ack & ctl.st;

  // base plus offset from the adder
  assign bud_adr = alu_sum;
  assign bud_wdt = gpr_rs2;

endmodule

/* source/rp_dec.sv */
`timescale 1ns/10ps
`include "rp_consts.svh"

module rp_dec (
  input  logic [`RP_XW-1:0] inst,
  output rp_pkg::ctl_t      ctl
);

  import rp_pkg::*;

  ////////////////////
  // fields
  ////////////////////

  opc_t              opc;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [`RP_XW-1:0] imm_i;
  logic [`RP_XW-1:0] imm_s;
  logic [`RP_XW-1:0] imm_b;
  logic [`RP_XW-1:0] imm_u;
  logic [`RP_XW-1:0] imm_j;

  assign opc    = opc_t'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // immediates, all sign extended from inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  ////////////////////
  // control word
  ////////////////////

  always_comb begin
    // start from a cleared word, second operand from immediate
    ctl     = '0;
    ctl.a2  = A2_IMM;
    ctl.imm = imm_i;
    case (opc)
      OPC_LUI: begin
        ctl.a1  = A1_ZERO;
        ctl.imm = imm_u;
        ctl.wb  = WB_ALU;
      end
      OPC_AUIPC: begin
        ctl.a1  = A1_PC;
        ctl.imm = imm_u;
        ctl.wb  = WB_ALU;
      end
      OPC_JAL: begin
        // target pc+imm from the adder, link pc+4
        ctl.a1  = A1_PC;
        ctl.imm = imm_j;
        ctl.br  = BR_ALW;
        ctl.wb  = WB_PC4;
      end
      OPC_JALR: begin
        ctl.br  = BR_ALW;
        ctl.wb  = WB_PC4;
        ctl.ill = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctl.a1  = A1_PC;
        ctl.imm = imm_b;
        case (funct3)
          3'b000:  ctl.br = BR_EQ;
          3'b001:  ctl.br = BR_NE;
          3'b100:  ctl.br = BR_LT;
          3'b101:  ctl.br = BR_GE;
          3'b110:  ctl.br = BR_LTU;
          3'b111:  ctl.br = BR_GEU;
          default: ctl.ill = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // word only
        ctl.ld  = 1'b1;
        ctl.wb  = WB_LD;
        ctl.ill = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        ctl.st  = 1'b1;
        ctl.imm = imm_s;
        ctl.ill = (funct3 != 3'b010);
      end
      OPC_OP_IMM: begin
        ctl.wb = WB_ALU;
        case (funct3)
          3'b001: begin
            ctl.ao  = AO_SLL;
            ctl.ill = (funct7 != 7'b0000000);
          end
          3'b101: begin
            // srai carries funct7[5] in the immediate
            ctl.ao  = ao_t'({funct7[5], funct3});
            ctl.ill = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
          default: ctl.ao = ao_t'({1'b0, funct3});
        endcase
      end
      OPC_OP: begin
        ctl.a2 = A2_RS2;
        ctl.wb = WB_ALU;
        if (funct7 == 7'b0000000) begin
          ctl.ao = ao_t'({1'b0, funct3});
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          // sub and sra
          ctl.ao = ao_t'({1'b1, funct3});
        end else begin
          ctl.ill = 1'b1;
        end
      end
      default: ctl.ill = 1'b1;
    endcase
    // illegal encodings turn into a bare nop
    if (ctl.ill) begin
      ctl     = '0;
      ctl.ill = 1'b1;
    end
  end

endmodule

/* source/rp_gpr.sv */
`timescale 1ns/10ps
`include "rp_consts.svh"

module rp_gpr #(
  parameter int unsigned AW = `RP_AW
)(
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  logic [AW-1:0]     a_rs1,
  input  logic [AW-1:0]     a_rs2,
  input  logic [AW-1:0]     a_rd,
  input  logic [`RP_XW-1:0] d_rd,
  output logic [`RP_XW-1:0] d_rs1,
  output logic [`RP_XW-1:0] d_rs2
);

  // register array cleared on reset
  // entry 0 is never written and so stays zero
  logic [`RP_XW-1:0] gpr [0:2**AW-1];

  // single write port
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 2**AW; i++) begin
        gpr[i[AW-1:0]] <= '0;
      end
    end else if (we && (a_rd != '0)) begin
      gpr[a_rd] <= d_rd;
    end
  end

  // asynchronous read ports
  assign d_rs1 = gpr[a_rs1];
  assign d_rs2 = gpr[a_rs2];

endmodule

/* source/rp_pkg.sv */
`include "rp_consts.svh"

package rp_pkg;

  ////////////////////
  // opcodes
  ////////////////////

  // major opcode field, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opc_t;

  ////////////////////
  // control fields
  ////////////////////

  // alu operation, encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    AO_ADD  = 4'b0000,
    AO_SUB  = 4'b1000,
    AO_SLL  = 4'b0001,
    AO_SLT  = 4'b0010,
    AO_SLTU = 4'b0011,
    AO_XOR  = 4'b0100,
    AO_SRL  = 4'b0101,
    AO_SRA  = 4'b1101,
    AO_OR   = 4'b0110,
    AO_AND  = 4'b0111
  } ao_t;

  // branch condition
  typedef enum logic [2:0] {
    BR_NONE, BR_ALW, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_t;

  // first and second alu operand source
  typedef enum logic [1:0] {A1_RS1, A1_PC, A1_ZERO} a1_t;
  typedef enum logic {A2_RS2, A2_IMM} a2_t;

  // write-back source
  typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_PC4, WB_LD} wb_t;

  // decoded control word
  // all-zero is a plain nop with nothing enabled
  typedef struct packed {
    ao_t              ao;
    br_t              br;
    a1_t              a1;
    a2_t              a2;
    wb_t              wb;
    logic             ld;   // word load
    logic             st;   // word store
    logic [`RP_XW-1:0] imm;
    logic             ill;  // unsupported encoding
  } ctl_t;

endpackage

/* test/rp_core_tb.sv */
`timescale 1ns/10ps
`include "rp_consts.svh"

module rp_core_tb;

  localparam int LIMIT = 4000;
  localparam logic [31:0] MARK = 32'h0000_03FC;

  logic        clk;
  logic        rst;
  logic        clr;
  logic        ld_en;
  logic [31:0] ld_adr;
  logic [31:0] ld_dat;
  logic [3:0]  dwait;
  logic        bup_req;
  logic        bup_ack;
  logic        bud_req;
  logic        bud_wen;
  logic        bud_ack;
  logic [31:0] bup_adr;
  logic [31:0] bup_rdt;
  logic [31:0] bud_adr;
  logic [31:0] bud_wdt;
  logic [31:0] bud_rdt;
  logic        mark;

  // program image and expected write log
  logic [31:0] prog [0:255];
  int          prog_n;
  logic [31:0] exp_adr[$];
  logic [31:0] exp_dat[$];
  logic [31:0] seed = 32'h72623642;
  int          errors;
  int          ntests;
  int          err0;
  int          cyc = 0;

  rp_tb_mem #(.MARK(MARK)) u_mem (
    .clk(clk), .rst(rst), .clr(clr), .ld_en(ld_en), .ld_adr(ld_adr), .ld_dat(ld_dat),
    .dwait(dwait), .bup_req(bup_req), .bup_adr(bup_adr), .bup_rdt(bup_rdt),
    .bup_ack(bup_ack), .bud_req(bud_req), .bud_wen(bud_wen), .bud_adr(bud_adr),
    .bud_wdt(bud_wdt), .bud_rdt(bud_rdt), .bud_ack(bud_ack), .mark(mark)
  );

  rp_core uut (
    .clk(clk), .rst(rst), .bup_req(bup_req), .bup_adr(bup_adr), .bup_rdt(bup_rdt),
    .bup_ack(bup_ack), .bud_req(bud_req), .bud_wen(bud_wen), .bud_adr(bud_adr),
    .bud_wdt(bud_wdt), .bud_rdt(bud_rdt), .bud_ack(bud_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // limit covers five programs, preload and worst case data waits
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      errors = errors + 1;
    end
  endtask

  // instruction formats
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(logic [31:0] v, logic [4:0] rd, logic [6:0] op);
    return {v[31:12], rd, op};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // rv32i result rules per operation index k
  // k order is add sub sll slt sltu xor srl sra or and
  function automatic logic [31:0] alu_rule(int k, logic [31:0] a, logic [31:0] b);
    case (k)
      0: return a + b;
      1: return a - b;
      2: return a << b[4:0];
      3: return {31'b0, $signed(a) < $signed(b)};
      4: return {31'b0, a < b};
      5: return a ^ b;
      6: return a >> b[4:0];
      7: return $unsigned($signed(a) >>> b[4:0]);
      8: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [2:0] alu_f3(int k);
    case (k)
      0, 1: return 3'd0;
      2: return 3'd1;
      3: return 3'd2;
      4: return 3'd3;
      5: return 3'd4;
      6, 7: return 3'd5;
      8: return 3'd6;
      default: return 3'd7;
    endcase
  endfunction

  function automatic logic br_rule(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic put(input logic [31:0] w);
    prog[prog_n[7:0]] = w;
    prog_n = prog_n + 1;
  endtask

  task automatic li(input logic [4:0] rd, input logic [31:0] v);
    put(enc_u(v + 32'h800, rd, 7'h37));
    put(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
  endtask

  task automatic add_exp(input logic [31:0] adr, input logic [31:0] dat);
    exp_adr.push_back(adr);
    exp_dat.push_back(dat);
  endtask

  // store a register to the next result slot
  task automatic store_res(input logic [4:0] rs, input logic [31:0] val);
    logic [31:0] adr;
    adr = 32'h200 + 32'(exp_adr.size() * 4);
    put(enc_s(adr[11:0], rs, 5'd0));
    add_exp(adr, val);
  endtask

  task automatic begin_test();
    prog_n = 0;
    exp_adr.delete();
    exp_dat.delete();
    err0 = errors;
  endtask

  // reset with checks on the idle bus
  task automatic do_reset();
    rst = 1'b1;
    repeat (3) begin
      @(posedge clk);
      #1;
      check("reset bup_req", 32'd0, {31'b0, bup_req});
      check("reset bud_req", 32'd0, {31'b0, bud_req});
      check("reset bud_wen", 32'd0, {31'b0, bud_wen});
      check("reset bup_adr", `RP_PC0, bup_adr);
    end
    rst = 1'b0;
    check("first cycle bup_req", 32'd0, {31'b0, bup_req});
    check("first cycle bud_req", 32'd0, {31'b0, bud_req});
    check("first cycle bud_wen", 32'd0, {31'b0, bud_wen});
    @(posedge clk);
    #1;
    check("fetch request", 32'd1, {31'b0, bup_req});
    check("first fetch address", `RP_PC0, bup_adr);
  endtask

  // load, reset, run to the marker store and compare the log
  task automatic run_prog(input string name);
    put(enc_s(MARK[11:0], 5'd0, 5'd0));
    rst = 1'b1;
    clr = 1'b1;
    @(posedge clk);
    #1;
    clr = 1'b0;
    ld_en = 1'b1;
    for (int i = 0; i < prog_n; i++) begin
      ld_adr = 32'(i * 4);
      ld_dat = prog[i[7:0]];
      @(posedge clk);
      #1;
    end
    ld_en = 1'b0;
    do_reset();
    while (!mark) begin
      @(posedge clk);
      #1;
      dwait = 4'(next_rand() % 11);
    end
    check({name, " write count"}, 32'(exp_adr.size() + 1), {25'b0, u_mem.log_n});
    for (int i = 0; i < exp_adr.size() && i < 127; i++) begin
      check({name, " address"}, exp_adr[i], u_mem.log_adr[i[6:0]]);
      check({name, " data"}, exp_dat[i], u_mem.log_dat[i[6:0]]);
    end
    ntests = ntests + 1;
    $display("%s: %s", name, (errors == err0) ? "ok" : "errors");
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_reset();
    begin_test();
    run_prog("reset state");
  endtask

  task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] bv;
    logic [11:0] imm;
    int          iks [9];
    begin_test();
    iks = '{0, 3, 4, 5, 8, 9, 2, 6, 7};
    a = next_rand();
    b = next_rand();
    li(5'd1, a);
    li(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      put(enc_r((k == 1 || k == 7) ? 7'h20 : 7'h00, 5'd2, 5'd1, alu_f3(k), 5'd3, 7'h33));
      store_res(5'd3, alu_rule(k, a, b));
    end
    foreach (iks[n]) begin
      r = next_rand();
      if (iks[n] == 2 || iks[n] == 6 || iks[n] == 7) begin
        imm = {(iks[n] == 7) ? 7'h20 : 7'h00, r[4:0]};
        bv  = {27'b0, r[4:0]};
      end else begin
        imm = r[11:0];
        bv  = {{20{r[11]}}, r[11:0]};
      end
      put(enc_i(imm, 5'd1, alu_f3(iks[n]), 5'd3, 7'h13));
      store_res(5'd3, alu_rule(iks[n], a, bv));
    end
    r = next_rand();
    put(enc_u(r, 5'd3, 7'h37));
    store_res(5'd3, {r[31:12], 12'b0});
    r = next_rand();
    bv = 32'(prog_n * 4);
    put(enc_u(r, 5'd3, 7'h17));
    store_res(5'd3, bv + {r[31:12], 12'b0});
    run_prog("alu operations");
  endtask

  // taken path logs 2 and fall-through logs 1
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [31:0] a, input logic [31:0] b);
    put(enc_b(13'd12, rs1, rs2, f3));
    put(enc_i(12'd1, 5'd0, 3'd0, 5'd7, 7'h13));
    put(enc_j(21'd8, 5'd0));
    put(enc_i(12'd2, 5'd0, 3'd0, 5'd7, 7'h13));
    store_res(5'd7, br_rule(f3, a, b) ? 32'd2 : 32'd1);
  endtask

  task automatic test_branch();
    logic [31:0] v;
    logic [31:0] m5;
    logic [31:0] p;
    begin_test();
    v  = next_rand();
    m5 = 32'hFFFF_FFFB;
    li(5'd1, v);
    put(enc_i(12'hFFB, 5'd0, 3'd0, 5'd5, 7'h13));
    put(enc_i(12'd3, 5'd0, 3'd0, 5'd6, 7'h13));
    branch_case(3'd0, 5'd1, 5'd1, v, v);
    branch_case(3'd0, 5'd5, 5'd6, m5, 32'd3);
    branch_case(3'd1, 5'd5, 5'd6, m5, 32'd3);
    branch_case(3'd1, 5'd6, 5'd6, 32'd3, 32'd3);
    branch_case(3'd4, 5'd5, 5'd6, m5, 32'd3);
    branch_case(3'd4, 5'd6, 5'd5, 32'd3, m5);
    branch_case(3'd5, 5'd6, 5'd5, 32'd3, m5);
    branch_case(3'd5, 5'd5, 5'd6, m5, 32'd3);
    branch_case(3'd6, 5'd6, 5'd5, 32'd3, m5);
    branch_case(3'd6, 5'd5, 5'd6, m5, 32'd3);
    branch_case(3'd7, 5'd5, 5'd6, m5, 32'd3);
    branch_case(3'd7, 5'd6, 5'd5, 32'd3, m5);
    // jal skips one word and links pc+4
    p = 32'(prog_n * 4);
    put(enc_j(21'd8, 5'd8));
    put(enc_i(12'd5, 5'd0, 3'd0, 5'd12, 7'h13));
    store_res(5'd8, p + 32'd4);
    // jalr with odd offset lands on the even word
    p = 32'(prog_n * 4);
    put(enc_u(32'd0, 5'd10, 7'h17));
    put(enc_i(12'd13, 5'd10, 3'd0, 5'd11, 7'h67));
    put(enc_i(12'd7, 5'd0, 3'd0, 5'd12, 7'h13));
    // landing pc read back through auipc
    put(enc_u(32'd0, 5'd13, 7'h17));
    store_res(5'd11, p + 32'd8);
    store_res(5'd12, 32'd0);
    store_res(5'd13, p + 32'd12);
    run_prog("branches and jumps");
  endtask

  task automatic test_ldst();
    logic [31:0] vals [6];
    logic [31:0] off;
    begin_test();
    put(enc_i(12'h280, 5'd0, 3'd0, 5'd20, 7'h13));
    for (int k = 0; k < 6; k++) begin
      vals[k] = next_rand();
      off = 32'(k * 8 - 16);
      li(5'd1, vals[k]);
      put(enc_s(off[11:0], 5'd1, 5'd20));
      add_exp(32'h280 + off, vals[k]);
    end
    // read back and copy to a second area
    for (int k = 0; k < 6; k++) begin
      off = 32'(k * 8 - 16);
      put(enc_i(off[11:0], 5'd20, 3'd2, 5'd2, 7'h03));
      off = 32'(256 + k * 4);
      put(enc_s(off[11:0], 5'd2, 5'd20));
      add_exp(32'h280 + off, vals[k]);
    end
    run_prog("load and store");
  endtask

  task automatic test_x0();
    begin_test();
    li(5'd1, next_rand());
    put(enc_i(12'd123, 5'd0, 3'd0, 5'd0, 7'h13));
    put(enc_u(32'hABCDE000, 5'd0, 7'h37));
    put(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd0, 7'h33));
    store_res(5'd0, 32'd0);
    put(enc_i(12'd1, 5'd1, 3'd0, 5'd0, 7'h13));
    store_res(5'd0, 32'd0);
    run_prog("register x0");
  endtask

  ////////////////////
  // main
  ////////////////////

  initial begin
    rst    = 1'b1;
    clr    = 1'b0;
    ld_en  = 1'b0;
    ld_adr = '0;
    ld_dat = '0;
    dwait  = '0;
    errors = 0;
    ntests = 0;
    test_reset();
    test_alu();
    test_branch();
    test_ldst();
    test_x0();
    $display("tests run %0d, failed checks %0d", ntests, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* test/rp_tb_mem.sv */
`timescale 1ns/10ps
`include "rp_consts.svh"

module rp_tb_mem #(
  parameter logic [`RP_XW-1:0] MARK = 32'h0000_03FC
)(
  input  logic              clk,
  input  logic              rst,
  // preload port, used while the core is in reset
  input  logic              clr,
  input  logic              ld_en,
  input  logic [`RP_XW-1:0] ld_adr,
  input  logic [`RP_XW-1:0] ld_dat,
  input  logic [3:0]        dwait,
  // program bus
  input  logic              bup_req,
  input  logic [`RP_XW-1:0] bup_adr,
  output logic [`RP_XW-1:0] bup_rdt,
  output logic              bup_ack,
  // data bus
  input  logic              bud_req,
  input  logic              bud_wen,
  input  logic [`RP_XW-1:0] bud_adr,
  input  logic [`RP_XW-1:0] bud_wdt,
  output logic [`RP_XW-1:0] bud_rdt,
  output logic              bud_ack,
  output logic              mark
);

  // 256 words, program low, data from 0x200
  logic [`RP_XW-1:0] mem [0:255];
  logic [`RP_XW-1:0] fadr;
  logic [3:0]        wcnt;

  // write log
  logic [`RP_XW-1:0] log_adr [0:127];
  logic [`RP_XW-1:0] log_dat [0:127];
  logic [6:0]        log_n;

  assign bup_rdt = mem[fadr[9:2]];
  assign bud_rdt = mem[bud_adr[9:2]];

  // ack once the wait count is used up
  assign bud_ack = bud_req && (wcnt >= dwait);

  ////////////////////
  // bus timing
  ////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      bup_ack <= 1'b0;
      fadr    <= '0;
      wcnt    <= '0;
    end else begin
      bup_ack <= bup_req;
      fadr    <= bup_adr;
      wcnt    <= (bud_req && !bud_ack) ? wcnt + 4'd1 : 4'd0;
    end
  end

  ////////////////////
  // storage and log
  ////////////////////

  always_ff @(posedge clk) begin
    if (clr) begin
      for (int i = 0; i < 256; i++) begin
        mem[i[7:0]] <= `RP_NOP;
      end
      log_n <= '0;
      mark  <= 1'b0;
    end else if (ld_en) begin
      mem[ld_adr[9:2]] <= ld_dat;
    end else if (bud_req && bud_ack && bud_wen) begin
      mem[bud_adr[9:2]] <= bud_wdt;
      if (log_n != 7'd127) begin
        log_adr[log_n] <= bud_adr;
        log_dat[log_n] <= bud_wdt;
        log_n          <= log_n + 7'd1;
      end
      // end of test program
      if (bud_adr == MARK) begin
        mark <= 1'b1;
      end
    end
  end

endmodule

/* verilog.f */
+incdir+include
source/rp_pkg.sv
source/rp_dec.sv
source/rp_gpr.sv
source/rp_alu.sv
source/rp_br.sv
source/rp_core.sv
test/rp_tb_mem.sv
test/rp_core_tb.sv
